// File: sources.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
pipe_reg.sv
regfile.sv
id_stage.sv
ex_stage.sv
wb_stage.sv
core_top.sv
core_assertions.sv
tb_core.sv

// File: Bender.yml
package:
  name: rv32i_pipe

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - pipe_reg.sv
      - regfile.sv
      - id_stage.sv
      - ex_stage.sv
      - wb_stage.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_assertions.sv
      - tb_core.sv

// File: tb_core.sv
/*
 * Testbench for core_top
 * Xorshift instruction stimulus, RV32I reference model,
 * typed compare tasks and a watchdog
 */

`timescale 1ns/1ps
`include "core_params.svh"

module tb_core;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 16;
  localparam int N_INSTR        = 500;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_INSTR * 20;

  logic      clk_i;
  logic      rst_ni;
  logic      instr_valid_i;
  logic      instr_ready_o;
  instr_in_t instr_i;
  logic      retire_valid_o;
  logic      retire_ready_i;
  retire_t   retire_o;

  // Reference state
  xlen_t       model_regs [0:`NUM_REGS-1];
  retire_t     exp_q [$];
  logic [31:0] rng_q;
  int          errors;
  int          retired;
  int          sent;

  core_top uut (
    .clk_i, .rst_ni,
    .instr_valid_i, .instr_ready_o, .instr_i,
    .retire_valid_o, .retire_ready_i, .retire_o
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  ////////////////////
  // Random numbers
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  // Mostly x0..x7 so hazards show up often
  function automatic reg_addr_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] != 2'b00) begin
      return reg_addr_t'(r[4:2]);
    end
    return r[8:4];
  endfunction

  function automatic logic [31:0] gen_instr();
    logic [31:0] r;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    reg_addr_t   rd, rs1, rs2;
    r   = next_rand();
    imm = next_rand();
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    f3  = r[2:0];
    f7  = r[3] ? F7_ALT : F7_BASE;
    case (r[6:4])
      3'd0: return {f7, rs2, rs1, f3, rd, OPC_OP};
      3'd1: begin
        // Shift immediates carry funct7 above the shift amount
        if (f3 == F3_SR) begin
          return {f7, imm[4:0], rs1, f3, rd, OPC_OP_IMM};
        end
        if (f3 == F3_SLL) begin
          return {F7_BASE, imm[4:0], rs1, f3, rd, OPC_OP_IMM};
        end
        return {imm[11:0], rs1, f3, rd, OPC_OP_IMM};
      end
      3'd2: return {imm[19:0], rd, OPC_LUI};
      3'd3: return {imm[19:0], rd, OPC_AUIPC};
      3'd4: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
      3'd5: return {imm[11:0], rs1, F3_ADD, rd, OPC_JALR};
      3'd6: begin
        // funct3 2 and 3 folded onto BLTU and BGEU
        if (f3[2:1] == 2'b01) begin
          f3 = {1'b1, f3[1:0]};
        end
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
      end
      default: begin
        // Load, store, bad branch funct3, bad JALR funct3
        case (r[9:8])
          2'd0:    return {imm[31:7], 7'b0000011};
          2'd1:    return {imm[31:7], 7'b0100011};
          2'd2:    return {imm[31:15], 3'b011, imm[11:7], OPC_BRANCH};
          default: return {imm[31:15], 3'b001, imm[11:7], OPC_JALR};
        endcase
      end
    endcase
  endfunction

  ////////////////////
  // RV32I reference model
  function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Executes one accepted instruction and updates the model registers
  task automatic model_exec(input logic [31:0] ins, input xlen_t pc, output retire_t e);
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a, b, imm_i, imm_b, imm_j, imm_u;
    f3    = ins[14:12];
    f7    = ins[31:25];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    e     = '0;
    e.pc  = pc;
    e.npc = pc + xlen_t'(`PC_INCR);
    e.rd  = ins[11:7];
    e.we  = 1'b1;
    case (ins[6:0])
      7'b0110011: begin
        e.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        e.result  = alu_ref(f3, f7[5], a, b);
      end
      7'b0010011: begin
        e.illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                    (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        e.result  = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm_i);
      end
      7'b0110111: e.result = imm_u;
      7'b0010111: e.result = pc + imm_u;
      7'b1101111: begin
        e.result = pc + 32'd4;
        e.npc    = pc + imm_j;
      end
      7'b1100111: begin
        e.illegal = (f3 != 3'd0);
        e.result  = pc + 32'd4;
        e.npc     = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        e.we      = 1'b0;
        e.illegal = (f3 == 3'd2 || f3 == 3'd3);
        if (branch_taken(f3, a, b)) begin
          e.npc = pc + imm_b;
        end
      end
      default: e.illegal = 1'b1;
    endcase
    if (e.illegal) begin
      e.we = 1'b0;
    end
    // x0 stays zero
    if (e.we && e.rd != 5'd0) begin
      model_regs[e.rd] = e.result;
    end
  endtask

  ////////////////////
  // Compare tasks
  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Record on the port against the oldest outstanding instruction
  task automatic check_retire();
    retire_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Retire record at %0t with no instruction outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      check_word("retire_o.pc", retire_o.pc, e.pc);
      check_flag("retire_o.illegal", retire_o.illegal, e.illegal);
      check_flag("retire_o.we", retire_o.we, e.we);
      if (!e.illegal) begin
        check_word("retire_o.npc", retire_o.npc, e.npc);
      end
      if (e.we) begin
        check_reg("retire_o.rd", retire_o.rd, e.rd);
        check_word("retire_o.result", retire_o.result, e.result);
      end
      retired++;
    end
  endtask

  ////////////////////
  // Stimulus and checking
  initial begin
    retire_t e;
    retire_t held_rec;
    xlen_t   pc;
    logic    accepted;
    logic    held;
    int      total;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    retire_ready_i = 1'b0;
    rng_q          = 32'h112f;
    errors         = 0;
    retired        = 0;
    sent           = 0;
    accepted       = 1'b0;
    held           = 1'b0;
    held_rec       = '0;
    pc             = 32'h0000_1000;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    while (retired < N_INSTR) begin
      @(negedge clk_i);
      // Instruction taken on the last edge leaves the port
      if (accepted) begin
        instr_valid_i = 1'b0;
      end
      retire_ready_i = (next_rand() % 4) != 0;
      if (!instr_valid_i && sent < N_INSTR && (next_rand() % 4) != 0) begin
        instr_i.instr = gen_instr();
        instr_i.pc    = pc;
        pc            = pc + 32'd4;
        instr_valid_i = 1'b1;
      end
      // Handshake values are settled here until the next rising edge
      #(CLK_PERIOD/4);
      if (held && !retire_valid_o) begin
        errors++;
        $display("retire_valid_o dropped before the record was taken at %0t", $time);
      end else if (held && retire_o !== held_rec) begin
        errors++;
        $display("MISMATCH retire_o while held got 0x%h expected 0x%h", retire_o, held_rec);
      end
      if (retire_valid_o && retire_ready_i) begin
        check_retire();
      end
      held     = retire_valid_o && !retire_ready_i;
      held_rec = retire_o;
      accepted = instr_valid_i && instr_ready_o;
      if (accepted) begin
        model_exec(instr_i.instr, instr_i.pc, e);
        exp_q.push_back(e);
        sent++;
      end
    end

    // Nothing may retire after the last record
    repeat (4) begin
      @(negedge clk_i);
      instr_valid_i  = 1'b0;
      retire_ready_i = 1'b1;
      #(CLK_PERIOD/4);
      if (retire_valid_o) begin
        errors++;
        $display("Extra retire record after all instructions at %0t", $time);
      end
    end

    total = errors + uut.u_assert.fail_count;
    $display("Errors: %0d (checks %0d, assertions %0d), retired %0d of %0d",
             total, errors, uut.u_assert.fail_count, retired, N_INSTR);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, retired %0d of %0d, errors %0d",
             TIMEOUT_CYCLES, retired, N_INSTR, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: core_assertions.sv
/*
 * Handshake assertions bound into core_top
 * Valid and payload hold on both streams, idle outputs in reset
 */

`timescale 1ns/1ps

module core_assertions (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                instr_valid_i,
  input logic                instr_ready_o,
  input pipe_pkg::instr_in_t instr_i,
  input logic                retire_valid_o,
  input logic                retire_ready_i,
  input pipe_pkg::retire_t   retire_o
);

  // Failures so far, read back by the testbench
  int fail_count = 0;

  // Offered instruction waits unchanged for ready
  a_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i && !instr_ready_o |=> instr_valid_i && $stable(instr_i))
  else begin
    fail_count++;
    $error("instruction valid or payload changed before ready");
  end

  // Retire record held until taken
  a_retire_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o))
  else begin
    fail_count++;
    $error("retire valid or record changed before ready");
  end

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> !instr_ready_o && !retire_valid_o)
  else begin
    fail_count++;
    $error("handshake outputs active during reset");
  end

endmodule

bind core_top core_assertions u_assert (.*);

// File: core_top.sv
/*
 * Core top level
 * Decode, two pipeline registers, execute, result stage and register file
 */

`timescale 1ns/1ps

module core_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  pipe_pkg::instr_in_t instr_i,
  output logic                retire_valid_o,
  input  logic                retire_ready_i,
  output pipe_pkg::retire_t   retire_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  // Decode to ID/EX register
  logic      id_valid, id_ready;
  id_ex_t    id_out;
  // ID/EX register to execute, execute to EX/WB register
  logic      ex_valid, ex_ready;
  id_ex_t    ex_in;
  ex_wb_t    ex_out;
  // EX/WB register to result stage
  logic      wb_valid, wb_ready;
  ex_wb_t    wb_in;

  wb_write_t wb_write;
  reg_addr_t raddr_a, raddr_b;
  xlen_t     rdata_a, rdata_b;

  id_stage u_id (
    .clk_i, .rst_ni, .instr_valid_i, .instr_ready_o, .instr_i,
    .raddr_a_o(raddr_a), .raddr_b_o(raddr_b),
    .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
    .wb_i(wb_write),
    .out_valid_o(id_valid), .out_ready_i(id_ready), .out_o(id_out)
  );

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk_i, .rst_ni,
    .in_valid_i(id_valid), .in_ready_o(id_ready), .in_data_i(id_out),
    .out_valid_o(ex_valid), .out_ready_i(ex_ready), .out_data_o(ex_in)
  );

  ex_stage u_ex (.in_i(ex_in), .out_o(ex_out));

  pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
    .clk_i, .rst_ni,
    .in_valid_i(ex_valid), .in_ready_o(ex_ready), .in_data_i(ex_out),
    .out_valid_o(wb_valid), .out_ready_i(wb_ready), .out_data_o(wb_in)
  );

  wb_stage u_wb (
    .in_valid_i(wb_valid), .in_ready_o(wb_ready), .in_i(wb_in),
    .retire_valid_o, .retire_ready_i, .retire_o,
    .wb_o(wb_write)
  );

  regfile u_rf (
    .clk_i, .rst_ni,
    .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
    .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
    .wr_i(wb_write)
  );

endmodule

// File: wb_stage.sv
/*
 * Result stage
 * Presents the retire record and commits the register write on transfer
 */

`timescale 1ns/1ps

module wb_stage (
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  pipe_pkg::ex_wb_t    in_i,
  output logic                retire_valid_o,
  input  logic                retire_ready_i,
  output pipe_pkg::retire_t   retire_o,
  output pipe_pkg::wb_write_t wb_o
);

  logic retire_fire;

  // Record leaves the core exactly when the outside takes it
  assign retire_valid_o = in_valid_i;
  assign in_ready_o     = retire_ready_i;
  assign retire_fire    = in_valid_i & retire_ready_i;

  always_comb begin
    retire_o.pc      = in_i.pc;
    retire_o.npc     = in_i.npc;
    retire_o.rd      = in_i.rd;
    retire_o.we      = in_i.we;
    retire_o.result  = in_i.result;
    retire_o.illegal = in_i.illegal;
  end

  // Write port pulses on the retire edge only
  always_comb begin
    wb_o.we   = retire_fire & in_i.we & ~in_i.illegal;
    wb_o.rd   = in_i.rd;
    wb_o.data = in_i.result;
  end

endmodule

// File: ex_stage.sv
/*
 * Execute stage
 * ALU, branch comparator and next-PC selection, purely combinational
 */

`timescale 1ns/1ps
`include "core_params.svh"

module ex_stage (
  input  pipe_pkg::id_ex_t in_i,
  output pipe_pkg::ex_wb_t out_o
);

  import isa_pkg::*;

  logic [4:0]              shamt;
  xlen_t                   sum;
  xlen_t                   alu_res;
  xlen_t                   link;
  xlen_t                   br_target;
  logic signed [`XLEN-1:0] sra_res;
  logic                    eq, lt, ltu, taken;

  ////////////////////
  // ALU
  assign shamt   = in_i.op_b[4:0];
  assign sum     = in_i.op_a + in_i.op_b;
  assign sra_res = $signed(in_i.op_a) >>> shamt;

  always_comb begin
    case (in_i.alu_op)
      ALU_ADD:  alu_res = sum;
      ALU_SUB:  alu_res = in_i.op_a - in_i.op_b;
      ALU_AND:  alu_res = in_i.op_a & in_i.op_b;
      ALU_OR:   alu_res = in_i.op_a | in_i.op_b;
      ALU_XOR:  alu_res = in_i.op_a ^ in_i.op_b;
      ALU_SLL:  alu_res = in_i.op_a << shamt;
      ALU_SRL:  alu_res = in_i.op_a >> shamt;
      ALU_SRA:  alu_res = xlen_t'(sra_res);
      ALU_SLT:  alu_res = xlen_t'($signed(in_i.op_a) < $signed(in_i.op_b));
      ALU_SLTU: alu_res = xlen_t'(in_i.op_a < in_i.op_b);
      default:  alu_res = sum;
    endcase
  end

  ////////////////////
  // Branch compare on rs1 and rs2 values
  assign eq  = (in_i.op_a == in_i.rs2_val);
  assign lt  = ($signed(in_i.op_a) < $signed(in_i.rs2_val));
  assign ltu = (in_i.op_a < in_i.rs2_val);

  always_comb begin
    case (in_i.br_cond)
      BR_EQ:   taken = eq;
      BR_NE:   taken = ~eq;
      BR_LT:   taken = lt;
      BR_GE:   taken = ~lt;
      BR_LTU:  taken = ltu;
      BR_GEU:  taken = ~ltu;
      default: taken = 1'b0;
    endcase
  end

  // Sequential PC doubles as the jump link value
  assign link      = in_i.pc + xlen_t'(`PC_INCR);
  assign br_target = in_i.pc + in_i.imm;

  always_comb begin
    out_o.pc      = in_i.pc;
    out_o.rd      = in_i.rd;
    out_o.we      = in_i.we;
    out_o.illegal = in_i.illegal;
    out_o.result  = in_i.jump ? link : alu_res;

    // JAL and JALR targets come from the ALU sum, bit 0 dropped
    if (in_i.jump) begin
      out_o.npc = {sum[`XLEN-1:1], 1'b0};
    end else if (taken) begin
      out_o.npc = br_target;
    end else begin
      out_o.npc = link;
    end
  end

endmodule

// File: id_stage.sv
/*
 * Decode stage
 * Instruction decoder, immediate generation, operand muxes
 * and a busy-register scoreboard that holds issue on hazards
 */

`timescale 1ns/1ps
`include "core_params.svh"

module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  pipe_pkg::instr_in_t instr_i,
  output isa_pkg::reg_addr_t  raddr_a_o,
  output isa_pkg::reg_addr_t  raddr_b_o,
  input  isa_pkg::xlen_t      rdata_a_i,
  input  isa_pkg::xlen_t      rdata_b_i,
  input  pipe_pkg::wb_write_t wb_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output pipe_pkg::id_ex_t    out_o
);

  import isa_pkg::*;

  logic [31:0] instr;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rs1, rs2, rd;
  xlen_t       imm_i, imm_b, imm_u, imm_j;

  // Decoder outputs
  alu_op_e     alu_op;
  op_a_sel_e   a_sel;
  op_b_sel_e   b_sel;
  xlen_t       imm;
  br_cond_e    br_cond;
  logic        jump, wr_en, use_rs1, use_rs2, illegal;

  xlen_t       op_a, op_b;
  logic [`NUM_REGS-1:0] busy_q;
  logic        run_q, hazard, issue;

  // Base ALU op from funct3, SUB and SRA patched by the caller
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3);
    case (f3)
      F3_ADD:  return ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  ////////////////////
  // Fields and immediates
  assign instr  = instr_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  ////////////////////
  // Decoder
  always_comb begin
    alu_op  = ALU_ADD;
    a_sel   = OP_A_REG;
    b_sel   = OP_B_IMM;
    imm     = imm_i;
    br_cond = BR_NONE;
    jump    = 1'b0;
    wr_en   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    illegal = 1'b0;

    case (opcode)
      OPC_OP: begin
        b_sel   = OP_B_REG;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        wr_en   = 1'b1;
        if (funct7 == F7_BASE) begin
          alu_op = alu_from_f3(funct3);
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          alu_op = ALU_SUB;
        end else if (funct7 == F7_ALT && funct3 == F3_SR) begin
          alu_op = ALU_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        wr_en   = 1'b1;
        alu_op  = alu_from_f3(funct3);
        // Shift immediates keep funct7 in the upper bits
        if (funct3 == F3_SLL && funct7 != F7_BASE) begin
          illegal = 1'b1;
        end else if (funct3 == F3_SR && funct7 == F7_ALT) begin
          alu_op = ALU_SRA;
        end else if (funct3 == F3_SR && funct7 != F7_BASE) begin
          illegal = 1'b1;
        end
      end
      OPC_LUI: begin
        a_sel = OP_A_ZERO;
        imm   = imm_u;
        wr_en = 1'b1;
      end
      OPC_AUIPC: begin
        a_sel = OP_A_PC;
        imm   = imm_u;
        wr_en = 1'b1;
      end
      // Jumps add target on the ALU, link comes from EX
      OPC_JAL: begin
        a_sel = OP_A_PC;
        imm   = imm_j;
        jump  = 1'b1;
        wr_en = 1'b1;
      end
      OPC_JALR: begin
        use_rs1 = 1'b1;
        jump    = 1'b1;
        wr_en   = 1'b1;
        illegal = (funct3 != F3_ADD);
      end
      OPC_BRANCH: begin
        b_sel   = OP_B_REG;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = imm_b;
        alu_op  = ALU_SUB;
        case (funct3)
          F3_BEQ:  br_cond = BR_EQ;
          F3_BNE:  br_cond = BR_NE;
          F3_BLT:  br_cond = BR_LT;
          F3_BGE:  br_cond = BR_GE;
          F3_BLTU: br_cond = BR_LTU;
          F3_BGEU: br_cond = BR_GEU;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings retire with no side effects
    if (illegal) begin
      wr_en   = 1'b0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      br_cond = BR_NONE;
      jump    = 1'b0;
    end
  end

  ////////////////////
  // Operand muxes
  assign raddr_a_o = rs1;
  assign raddr_b_o = rs2;

  always_comb begin
    case (a_sel)
      OP_A_REG: op_a = rdata_a_i;
      OP_A_PC:  op_a = instr_i.pc;
      default:  op_a = '0;
    endcase
  end

  assign op_b = (b_sel == OP_B_IMM) ? imm : rdata_b_i;

  ////////////////////
  // Scoreboard and issue
  // Sources wait for their writer, rd busy also blocks so one bit per reg is enough
  assign hazard = (use_rs1 & busy_q[rs1]) | (use_rs2 & busy_q[rs2]) | (wr_en & busy_q[rd]);

  assign out_valid_o   = instr_valid_i & run_q & ~hazard;
  assign instr_ready_o = run_q & ~hazard & out_ready_i;
  assign issue         = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      busy_q <= '0;
    end else begin
      // Issue opens one cycle after reset release
      run_q <= 1'b1;
      if (wb_i.we) begin
        busy_q[wb_i.rd] <= 1'b0;
      end
      if (issue && wr_en && (rd != '0)) begin
        busy_q[rd] <= 1'b1;
      end
    end
  end

  always_comb begin
    out_o.pc      = instr_i.pc;
    out_o.alu_op  = alu_op;
    out_o.op_a    = op_a;
    out_o.op_b    = op_b;
    out_o.rs2_val = rdata_b_i;
    out_o.imm     = imm;
    out_o.br_cond = br_cond;
    out_o.jump    = jump;
    out_o.rd      = rd;
    out_o.we      = wr_en;
    out_o.illegal = illegal;
  end

endmodule

// File: regfile.sv
/*
 * Integer register file
 * Two combinational read ports, one write port, x0 reads as zero
 */

`timescale 1ns/1ps
`include "core_params.svh"

module regfile (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  isa_pkg::reg_addr_t  raddr_a_i,
  input  isa_pkg::reg_addr_t  raddr_b_i,
  output isa_pkg::xlen_t      rdata_a_o,
  output isa_pkg::xlen_t      rdata_b_o,
  input  pipe_pkg::wb_write_t wr_i
);

  import isa_pkg::*;

  // Storage for x1 upwards only
  xlen_t regs_q [1:`NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.rd != '0)) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // x0 hardwired
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: pipe_reg.sv
/*
 * Single-entry valid/ready pipeline register
 * Payload type is a parameter
 */

`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // Take new data when empty or when the held item leaves this cycle
  assign in_ready_o  = ~valid_q | out_ready_i;
  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only moves on an input transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

endmodule

// File: pipe_pkg.sv
/*
 * Payload records passed between pipeline stages and to the outside
 * Instruction input, ID/EX, EX/WB, retire record and register write port
 */

package pipe_pkg;

  // Instruction word with its fetch PC
  typedef struct packed {
    logic [31:0]    instr;
    isa_pkg::xlen_t pc;
  } instr_in_t;

  // Decoded instruction with operands already selected
  typedef struct packed {
    isa_pkg::xlen_t     pc;
    isa_pkg::alu_op_e   alu_op;
    isa_pkg::xlen_t     op_a;
    isa_pkg::xlen_t     op_b;
    isa_pkg::xlen_t     rs2_val;    // compared against op_a on branches
    isa_pkg::xlen_t     imm;
    isa_pkg::br_cond_e  br_cond;
    logic               jump;
    isa_pkg::reg_addr_t rd;
    logic               we;
    logic               illegal;
  } id_ex_t;

  typedef struct packed {
    isa_pkg::xlen_t     pc;
    isa_pkg::xlen_t     npc;
    isa_pkg::reg_addr_t rd;
    logic               we;
    isa_pkg::xlen_t     result;
    logic               illegal;
  } ex_wb_t;

  // External retire record
  typedef struct packed {
    isa_pkg::xlen_t     pc;
    isa_pkg::xlen_t     npc;
    isa_pkg::reg_addr_t rd;
    logic               we;
    isa_pkg::xlen_t     result;
    logic               illegal;
  } retire_t;

  typedef struct packed {
    logic               we;
    isa_pkg::reg_addr_t rd;
    isa_pkg::xlen_t     data;
  } wb_write_t;

endpackage

// File: isa_pkg.sv
/*
 * RV32I encoding types for the kept instruction subset
 * Major opcodes, funct3/funct7 codes, ALU and branch enums, operand selectors
 */

`include "core_params.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0]   xlen_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // Major opcodes, low two bits always 2'b11
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  //////////////////////
  // funct3 for ALU ops
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7, ALT selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_cond_e;

  typedef enum logic [1:0] { OP_A_REG, OP_A_PC, OP_A_ZERO } op_a_sel_e;
  typedef enum logic       { OP_B_REG, OP_B_IMM } op_b_sel_e;

endpackage

// File: core_params.svh
/*
 * Core sizing macros
 * Data and PC width, register file depth, register index width
 * and the sequential PC step
 */

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data path and PC width
`define XLEN 32

// Architectural integer registers, x0 included
`define NUM_REGS 32

// Register index width
`define REG_AW 5

// Step between sequential instructions, no compressed support
`define PC_INCR 4

`endif
